// File: design/corr_cfg_pkg.sv
// --------------------------------------------------
// corr_cfg_pkg: command opcodes, the command word and
// the configuration that steers the pulse correlator.
// --------------------------------------------------
package corr_cfg_pkg;

	localparam int MAX_INPUTS = 8;

	localparam logic [3:0] OP_SET_INV    = 4'd1;
	localparam logic [3:0] OP_CLR_INV    = 4'd2;
	localparam logic [3:0] OP_SET_WINDOW = 4'd3; // next byte is the window length.
	localparam logic [3:0] OP_START      = 4'd4;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] arg;
	} cmd_ctrl_t;

	typedef union packed {
		cmd_ctrl_t  ctrl;
		logic [7:0] data;
	} cmd_word_u;

	typedef struct packed {
		logic [7:0] invert_mask;
		logic [7:0] window_len; // samples per window, never zero.
	} corr_cfg_t;

endpackage

// File: design/corr_cmd_regs.sv
// --------------------------------------------------
// corr_cmd_regs: decodes command bytes into the invert
// mask, the window length and the start pulse.
// --------------------------------------------------
module corr_cmd_regs
	import corr_cfg_pkg::*;
#(
	parameter int NUM_INPUTS = 4
) (
	input  logic      intclk,
	input  logic      rst_n,
	input  cmd_word_u cmd_byte,
	input  logic      cmd_strobe,
	input  logic      busy,
	output corr_cfg_t cfg,
	output logic      start
);

	logic len_pending; // the next strobed byte is a window length.
	logic arg_ok;

	assign arg_ok = (cmd_byte.ctrl.arg < 4'(NUM_INPUTS)) &&
		(cmd_byte.ctrl.arg < 4'(MAX_INPUTS));

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.invert_mask <= '0;
			cfg.window_len <= 8'd1;
			len_pending <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (cmd_strobe) begin
				if (len_pending) begin
					// a zero length would never end, so it counts as one.
					cfg.window_len <= (cmd_byte.data == 8'd0) ? 8'd1 : cmd_byte.data;
					len_pending <= 1'b0;
				end else begin
					case (cmd_byte.ctrl.opcode)
						OP_SET_INV: begin
							if (arg_ok) begin
								cfg.invert_mask[cmd_byte.ctrl.arg[2:0]] <= 1'b1;
							end
						end
						OP_CLR_INV: begin
							if (arg_ok) begin
								cfg.invert_mask[cmd_byte.ctrl.arg[2:0]] <= 1'b0;
							end
						end
						OP_SET_WINDOW: len_pending <= 1'b1;
						OP_START: start <= !busy && !start; // busy rises a cycle late.
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: design/corr_frame_pkg.sv
// --------------------------------------------------
// corr_frame_pkg: frame header and the nibble word
// that carries correlator results out.
// --------------------------------------------------
package corr_frame_pkg;

	localparam logic [7:0] FRAME_HEADER = 8'hA5;

	typedef struct packed {
		logic [3:0] nibble;
		logic       valid;
		logic       last;  // high on the final nibble of a frame.
	} frame_nibble_t;

endpackage

// File: design/correlator_top.sv
// --------------------------------------------------
// correlator_top: pulse correlator with command
// registers, delay line, counters and frame output.
// --------------------------------------------------
module correlator_top
	import corr_cfg_pkg::*;
	import corr_frame_pkg::*;
#(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_COUNT  = 3,
	parameter int RESOLUTION = 16
) (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  cmd_word_u             cmd_byte,
	input  logic                  cmd_strobe,
	output frame_nibble_t         frame_out,
	output logic                  busy
);

	corr_cfg_t                                      cfg;
	logic                                           start;
	logic [(LAG_COUNT+1)*NUM_INPUTS-1:0]            taps;
	logic [NUM_INPUTS*(LAG_COUNT+1)*RESOLUTION-1:0] snapshot;
	logic                                           snap_valid;
	logic                                           done;

	corr_cmd_regs #(.NUM_INPUTS(NUM_INPUTS)) u_cmd_regs (
		.intclk(intclk), .rst_n(rst_n),
		.cmd_byte(cmd_byte), .cmd_strobe(cmd_strobe),
		.busy(busy), .cfg(cfg), .start(start)
	);

	sample_delay_line #(.NUM_INPUTS(NUM_INPUTS), .LAG_COUNT(LAG_COUNT)) u_delay (
		.intclk(intclk), .rst_n(rst_n),
		.line_in(line_in), .cfg(cfg), .taps(taps)
	);

	lag_counter_bank #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_COUNT(LAG_COUNT), .RESOLUTION(RESOLUTION)
	) u_counters (
		.intclk(intclk), .rst_n(rst_n),
		.cfg(cfg), .start(start), .taps(taps), .done(done),
		.busy(busy), .snapshot(snapshot), .snap_valid(snap_valid)
	);

	frame_serializer #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_COUNT(LAG_COUNT), .RESOLUTION(RESOLUTION)
	) u_serializer (
		.intclk(intclk), .rst_n(rst_n),
		.snapshot(snapshot), .snap_valid(snap_valid),
		.frame_out(frame_out), .done(done)
	);

endmodule

// File: design/frame_serializer.sv
// --------------------------------------------------
// frame_serializer: sends the header and the snapshot
// out one nibble per cycle, MSB first.
// --------------------------------------------------
module frame_serializer
	import corr_frame_pkg::*;
#(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_COUNT  = 3,
	parameter int RESOLUTION = 16
) (
	input  logic                                             intclk,
	input  logic                                             rst_n,
	input  logic [NUM_INPUTS*(LAG_COUNT+1)*RESOLUTION-1:0]   snapshot,
	input  logic                                             snap_valid,
	output frame_nibble_t                                    frame_out,
	output logic                                             done
);

	localparam int SNAP_W        = NUM_INPUTS * (LAG_COUNT + 1) * RESOLUTION;
	localparam int FRAME_NIBBLES = 2 + SNAP_W / 4;
	localparam int IDX_W         = $clog2(FRAME_NIBBLES);

	logic                       active;
	logic [IDX_W-1:0]           idx;    // nibble now on the output.
	logic [FRAME_NIBBLES*4-1:0] shreg;
	logic                       at_end;

	assign at_end = active && (idx == IDX_W'(FRAME_NIBBLES - 1));

	always_comb begin
		frame_out.nibble = shreg[FRAME_NIBBLES*4-1 -: 4];
		frame_out.valid = active;
		frame_out.last = at_end;
	end

	assign done = at_end;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			idx <= '0;
		end else begin
			if (snap_valid) begin
				active <= 1'b1;
				idx <= '0;
			end else if (active) begin
				idx <= idx + 1'b1;
				if (at_end) begin
					active <= 1'b0;
				end
			end
		end
	end

	// the header rides at the top so it leaves first.
	always_ff @(posedge intclk) begin
		if (snap_valid) begin
			shreg <= {FRAME_HEADER, snapshot};
		end else if (active) begin
			shreg <= {shreg[FRAME_NIBBLES*4-5:0], 4'h0};
		end
	end

endmodule

// File: design/lag_counter_bank.sv
// --------------------------------------------------
// lag_counter_bank: runs the integration window and
// counts pulses and lag coincidences per line.
// --------------------------------------------------
module lag_counter_bank
	import corr_cfg_pkg::*;
#(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_COUNT  = 3,
	parameter int RESOLUTION = 16
) (
	input  logic                                             intclk,
	input  logic                                             rst_n,
	input  corr_cfg_t                                        cfg,
	input  logic                                             start,
	input  logic [(LAG_COUNT+1)*NUM_INPUTS-1:0]              taps,
	input  logic                                             done,
	output logic                                             busy,
	output logic [NUM_INPUTS*(LAG_COUNT+1)*RESOLUTION-1:0]   snapshot,
	output logic                                             snap_valid
);

	localparam int TAPS  = LAG_COUNT + 1;
	localparam int SLOTS = NUM_INPUTS * TAPS;

	logic                        counting;
	logic [7:0]                  remaining; // samples left in the window.
	logic                        last_sample;
	logic [SLOTS*RESOLUTION-1:0] cnt;
	logic [SLOTS*RESOLUTION-1:0] cnt_next;

	assign last_sample = counting && (remaining == 8'd1);

	// slot 0 (line 0 pulses) sits at the top, the first count to leave.
	// lag 0 of a line is tap 0 against itself, which is the pulse count.
	always_comb begin
		cnt_next = cnt;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int k = 0; k < TAPS; k++) begin
				if (taps[i] && taps[k*NUM_INPUTS+i]) begin
					cnt_next[(SLOTS-1-(i*TAPS+k))*RESOLUTION +: RESOLUTION] =
						cnt[(SLOTS-1-(i*TAPS+k))*RESOLUTION +: RESOLUTION] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			counting <= 1'b0;
			remaining <= 8'd0;
			snap_valid <= 1'b0;
		end else begin
			snap_valid <= last_sample;
			if (start && !busy) begin
				busy <= 1'b1;
				counting <= 1'b1;
				remaining <= cfg.window_len;
			end else if (counting) begin
				remaining <= remaining - 8'd1;
				if (last_sample) begin
					counting <= 1'b0;
				end
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (start && !busy) begin
			cnt <= '0;
		end else if (counting) begin
			cnt <= cnt_next;
		end
		if (last_sample) begin
			snapshot <= cnt_next;
		end
	end

endmodule

// File: design/sample_delay_line.sv
// --------------------------------------------------
// sample_delay_line: inverts the input lines and keeps
// the last LAG_COUNT samples of each line.
// --------------------------------------------------
module sample_delay_line
	import corr_cfg_pkg::*;
#(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_COUNT  = 3
) (
	input  logic                                  intclk,
	input  logic                                  rst_n,
	input  logic [NUM_INPUTS-1:0]                 line_in,
	input  corr_cfg_t                             cfg,
	output logic [(LAG_COUNT+1)*NUM_INPUTS-1:0]   taps
);

	logic [NUM_INPUTS-1:0]           cur;
	logic [LAG_COUNT*NUM_INPUTS-1:0] hist; // tap k sits at slice k-1.

	assign cur = line_in ^ cfg.invert_mask[NUM_INPUTS-1:0];
	assign taps = {hist, cur};

	// every tap moves one slot deeper per cycle.
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			hist <= '0;
		end else begin
			hist <= taps[LAG_COUNT*NUM_INPUTS-1:0];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build the correlator testbench with Verilator, run it and look for the pass line.
verilator --binary --timing -f sources.f --top-module correlator_tb -o correlator_sim \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/correlator_sim 2>&1)
echo "$out"
echo "$out" | grep -qF "All tests passed!" \
	&& echo "result: pass" \
	|| { echo "result: fail"; exit 1; }

// File: sources.f
design/corr_cfg_pkg.sv
design/corr_frame_pkg.sv
design/corr_cmd_regs.sv
design/sample_delay_line.sv
design/lag_counter_bank.sv
design/frame_serializer.sv
design/correlator_top.sv
verification/correlator_tb.sv

// File: verification/correlator_tb.sv
// --------------------------------------------------
// correlator_tb: random lines and commands into the
// pulse correlator, every frame checked against a
// cycle model of windows, lags and inversion.
// --------------------------------------------------
module correlator_tb
	import corr_cfg_pkg::*;
	import corr_frame_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_INPUTS     = 4;
	localparam int LAG_COUNT      = 3;
	localparam int RESOLUTION     = 16;
	localparam int FRAME_NIB      = 2 + NUM_INPUTS * (LAG_COUNT + 1) * RESOLUTION / 4;
	localparam int FRAME_BITS     = FRAME_NIB * 4;
	localparam int NUM_WINDOWS    = 17;
	localparam int WINDOW_SLACK   = 64;
	localparam int TIMEOUT_CYCLES = NUM_WINDOWS * (255 + FRAME_NIB + WINDOW_SLACK) + 100;

	typedef logic [FRAME_BITS-1:0] frame_vec_t;

	logic                  intclk = 1'b0;
	logic                  rst_n;
	logic [NUM_INPUTS-1:0] line_in;
	cmd_word_u             cmd_byte;
	logic                  cmd_strobe;
	frame_nibble_t         frame_out;
	logic                  busy;

	logic [31:0] line_state = 32'd84594;
	logic [31:0] stim_state = 32'd84594 ^ 32'h5bd1e995;
	string       test_name = "reset";
	int          cycles = 0;
	int          windows_planned = 0;
	int          frames_seen = 0;
	int          nib_idx = 0;
	logic        check_fall = 1'b0;
	frame_vec_t  cur_exp;
	logic [3:0]  exp_nib;

	// model state.
	logic [NUM_INPUTS-1:0] m_hist [0:LAG_COUNT];
	int                    m_cnt [NUM_INPUTS][LAG_COUNT+1];
	logic [7:0]            m_mask, m_win, win_now;
	logic                  m_len_pending, m_arm, m_busy, arm_now, busy_now;
	int                    m_left, m_tail;
	frame_vec_t            fv;
	frame_vec_t            exp_q[$];

	correlator_top #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_COUNT(LAG_COUNT), .RESOLUTION(RESOLUTION)
	) u_dut (
		.intclk(intclk), .rst_n(rst_n), .line_in(line_in),
		.cmd_byte(cmd_byte), .cmd_strobe(cmd_strobe),
		.frame_out(frame_out), .busy(busy)
	);

	initial begin
		forever #2 intclk = ~intclk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] st);
		return st * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [7:0] next_byte();
		stim_state = lcg_step(stim_state);
		return stim_state[30:23];
	endfunction

	task automatic stop_with_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		stop_with_failure();
	endtask

	task automatic report_error(input string what);
		$display("ERROR in %s: %s", test_name, what);
		stop_with_failure();
	endtask

	task automatic send_cmd(input logic [7:0] value);
		@(negedge intclk);
		cmd_byte.data = value;
		cmd_strobe = 1'b1;
		@(negedge intclk);
		cmd_strobe = 1'b0;
	endtask

	task automatic set_window(input logic [7:0] len);
		send_cmd({OP_SET_WINDOW, 4'h0});
		send_cmd(len);
	endtask

	// issues one start and waits for its frame to leave.
	task automatic run_window();
		windows_planned++;
		send_cmd({OP_START, 4'h0});
		while (frames_seen < windows_planned) @(posedge intclk);
	endtask

	task automatic check_idle();
		assert (busy == 1'b0) else report_mismatch("busy", 0, int'(busy));
		assert (frame_out.valid == 1'b0) else report_mismatch("valid", 0, int'(frame_out.valid));
	endtask

	always @(negedge intclk) begin
		line_state = lcg_step(line_state);
		line_in <= line_state[31 -: NUM_INPUTS];
	end

	always @(posedge intclk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			report_error("the run did not finish before the cycle limit");
		end
	end

	// cycle model of the command rules, the delay line and the window.
	always @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k <= LAG_COUNT; k++) m_hist[k] = '0;
			m_mask = '0;
			m_win = 8'd1;
			{m_len_pending, m_arm, m_busy} = '0;
			m_left = 0;
			m_tail = 0;
		end else begin
			arm_now = m_arm;
			busy_now = m_busy;
			win_now = m_win;
			m_arm = 1'b0;
			for (int k = LAG_COUNT; k > 0; k--) m_hist[k] = m_hist[k-1];
			m_hist[0] = line_in ^ m_mask[NUM_INPUTS-1:0];
			if (m_left > 0) begin
				for (int i = 0; i < NUM_INPUTS; i++) begin
					for (int k = 0; k <= LAG_COUNT; k++) begin
						if (m_hist[0][i] && m_hist[k][i]) m_cnt[i][k]++;
					end
				end
				m_left--;
				if (m_left == 0) begin
					fv = '0;
					fv[7:0] = FRAME_HEADER;
					for (int i = 0; i < NUM_INPUTS; i++) begin
						for (int k = 0; k <= LAG_COUNT; k++) begin
							fv = {fv[FRAME_BITS-RESOLUTION-1:0], RESOLUTION'(m_cnt[i][k])};
						end
					end
					exp_q.push_back(fv);
					m_tail = FRAME_NIB + 1; // busy drops one cycle after the last nibble.
				end
			end else if (m_tail > 0) begin
				m_tail--;
				if (m_tail == 0) m_busy = 1'b0;
			end
			if (arm_now) begin
				for (int i = 0; i < NUM_INPUTS; i++) begin
					for (int k = 0; k <= LAG_COUNT; k++) m_cnt[i][k] = 0;
				end
				m_left = int'(win_now);
			end
			if (cmd_strobe) begin
				if (m_len_pending) begin
					m_win = (cmd_byte.data == 8'd0) ? 8'd1 : cmd_byte.data;
					m_len_pending = 1'b0;
				end else begin
					case (cmd_byte.ctrl.opcode)
						OP_SET_INV: begin
							if (int'(cmd_byte.ctrl.arg) < NUM_INPUTS) begin
								m_mask[cmd_byte.ctrl.arg[2:0]] = 1'b1;
							end
						end
						OP_CLR_INV: begin
							if (int'(cmd_byte.ctrl.arg) < NUM_INPUTS) begin
								m_mask[cmd_byte.ctrl.arg[2:0]] = 1'b0;
							end
						end
						OP_SET_WINDOW: m_len_pending = 1'b1;
						OP_START: begin
							if (!busy_now) begin
								m_arm = 1'b1;
								m_busy = 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// the frame monitor samples on the falling edge.
	always @(negedge intclk) begin
		if (rst_n) begin
			if (check_fall) begin
				assert (busy == 1'b0) else report_mismatch("busy_fall", 0, int'(busy));
				check_fall = 1'b0;
			end
			if (frame_out.valid) begin
				if (nib_idx == 0) begin
					assert (exp_q.size() > 0)
						else report_error("a frame started with no window pending");
					cur_exp = exp_q.pop_front();
				end
				exp_nib = cur_exp[(FRAME_NIB-1-nib_idx)*4 +: 4];
				assert (frame_out.nibble == exp_nib)
					else report_mismatch((nib_idx < 2) ? "header" : "counts", int'(exp_nib),
						int'(frame_out.nibble));
				assert (frame_out.last == (nib_idx == FRAME_NIB - 1))
					else report_mismatch("last", int'(nib_idx == FRAME_NIB - 1),
						int'(frame_out.last));
				if (frame_out.last) begin
					assert (busy == 1'b1) else report_mismatch("busy_hold", 1, int'(busy));
					check_fall = 1'b1;
					nib_idx = 0;
					frames_seen++;
				end else begin
					nib_idx++;
				end
			end else begin
				assert (nib_idx == 0) else report_error("frame_out.valid dropped inside a frame");
			end
		end
	end

	initial begin
		logic [7:0] r;
		rst_n = 1'b0;
		line_in = '0;
		cmd_byte = '0;
		cmd_strobe = 1'b0;
		repeat (4) begin
			@(negedge intclk);
			check_idle();
		end
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge intclk);
			check_idle();
		end

		test_name = "no_inversion";
		repeat (6) begin
			set_window(next_byte());
			run_window();
		end

		test_name = "inversion";
		repeat (6) begin
			repeat (2 + int'(next_byte() % 8'd4)) begin
				r = next_byte();
				send_cmd({r[7] ? OP_SET_INV : OP_CLR_INV, r[3:0]}); // args 4 to 15 are ignored.
			end
			send_cmd({4'h7, r[3:0]});
			set_window(next_byte());
			run_window();
		end

		test_name = "window_length";
		set_window(8'd0);
		run_window();
		set_window(8'd1);
		run_window();
		set_window(8'd255);
		run_window();

		test_name = "start_while_busy";
		set_window(8'd200);
		windows_planned++;
		send_cmd({OP_START, 4'h0});
		while (!busy) @(negedge intclk);
		send_cmd({OP_START, 4'h0}); // lands mid-window and must be dropped.
		while (frames_seen < windows_planned) @(posedge intclk);
		set_window(next_byte());
		run_window();

		test_name = "final_idle";
		repeat (10) @(negedge intclk);
		check_idle();
		assert (exp_q.size() == 0) else report_error("a predicted frame never appeared");
		$display("All tests passed!");
		$finish;
	end

endmodule
